// File: source/bru_defs.svh
// width and count macros for the branch resolution unit
`ifndef BRU_DEFS_SVH
`define BRU_DEFS_SVH

//////////////////////////////////////////////////
// datapath widths
//////////////////////////////////////////////////

// architectural data word
`define BRU_WORD_W      32

// pc counts words, so pc + 1 is the next instruction
`define BRU_PC_W        14

// branch immediate as dispatched
`define BRU_IMM_W       16

//////////////////////////////////////////////////
// core bookkeeping widths
//////////////////////////////////////////////////

// physical register tag
`define BRU_TAG_W       6

// rob entry index
`define BRU_ROB_W       6

// checkpoint column for restart
`define BRU_CKPT_W      3

// btb / dirp index, taken from low pc bits
`define BRU_BTB_IDX_W   4

// complete buses snooped for operand wakeup
`define BRU_NUM_CB      3

`endif

// File: source/bru_pkg.sv
// shared scalar typedefs, op and select enums, task, bus, restart and btb structs
`include "bru_defs.svh"

package bru_pkg;

    // scalar field types
    typedef logic [`BRU_WORD_W-1:0]    word_t;
    typedef logic [`BRU_PC_W-1:0]      pc_t;
    typedef logic [`BRU_TAG_W-1:0]     tag_t;
    typedef logic [`BRU_ROB_W-1:0]     rob_idx_t;
    typedef logic [`BRU_CKPT_W-1:0]    ckpt_col_t;
    typedef logic [`BRU_BTB_IDX_W-1:0] btb_idx_t;

    // branch ops handled here
    typedef enum logic [1:0] {
        BRU_BEQ = 2'd0,
        BRU_BNE = 2'd1,
        BRU_JR  = 2'd2
    } bru_op_t;

    // where ex picks an operand from
    typedef enum logic [1:0] {
        SEL_CB0 = 2'd0,
        SEL_CB1 = 2'd1,
        SEL_CB2 = 2'd2,
        SEL_RAW = 2'd3
    } src_sel_t;

    // per operand status from dispatch
    typedef struct packed {
        logic needed;
        logic ready;
        tag_t tag;
    } src_status_t;

    // dispatched task as held in the rs
    typedef struct packed {
        bru_op_t                op;
        src_status_t            source_0;
        src_status_t            source_1;
        logic [`BRU_IMM_W-1:0]  imm16;
        pc_t                    pc;
        pc_t                    npc;
        ckpt_col_t              ckpt_col;
        rob_idx_t               rob_index;
    } bru_task_t;

    // one complete bus, data trails tag by a cycle
    typedef struct packed {
        logic  tag_valid;
        tag_t  tag;
        word_t data;
    } cb_t;

    // ex stage register contents
    typedef struct packed {
        logic      valid;
        bru_op_t   op;
        word_t     raw_0;
        word_t     raw_1;
        src_sel_t  sel_0;
        src_sel_t  sel_1;
        btb_idx_t  btb_idx;
        pc_t       branch_pc;
        pc_t       next_pc;
        pc_t       npc;
        ckpt_col_t ckpt_col;
        rob_idx_t  rob_index;
    } ex_task_t;

    // restart to rob
    typedef struct packed {
        rob_idx_t  rob_index;
        pc_t       pc;
        ckpt_col_t safe_col;
    } restart_t;

    // btb / dirp training
    typedef struct packed {
        btb_idx_t idx;
        pc_t      target;
        logic     taken;
    } btb_update_t;

endpackage

// File: source/bru_operand_wakeup.sv
// operand tag match against the complete buses with fixed priority select
`include "bru_defs.svh"

module bru_operand_wakeup
    import bru_pkg::*;
(
    input  src_status_t src,
    input  cb_t         cb_0,
    input  cb_t         cb_1,
    input  cb_t         cb_2,
    output logic        hit,
    output src_sel_t    sel
);

    // buses as an array so the match is one loop
    cb_t                   cbs [`BRU_NUM_CB];
    logic [`BRU_NUM_CB-1:0] match;

    assign cbs[0] = cb_0;
    assign cbs[1] = cb_1;
    assign cbs[2] = cb_2;

    // only a needed, still waiting operand can wake up
    always_comb begin
        for (int i = 0; i < `BRU_NUM_CB; i++) begin
            match[i] = src.needed & ~src.ready & cbs[i].tag_valid &
                       (cbs[i].tag == src.tag);
        end
    end

    // bus 0 wins, so walk from the highest bus down
    always_comb begin
        hit = 1'b0;
        sel = SEL_RAW;
        for (int i = `BRU_NUM_CB - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit = 1'b1;
                sel = src_sel_t'(2'(i));
            end
        end
    end

endmodule

// File: source/bru_rs_control.sv
// single entry reservation station with issue, kill, wakeup marking and read request
module bru_rs_control
    import bru_pkg::*;
(
    input  logic      CLK,
    input  logic      nRST,

    // dispatch
    input  logic      dispatch_valid,
    input  bru_task_t dispatch_task,

    // wakeup results for the held task
    input  logic      hit_0,
    input  logic      hit_1,

    // register file
    input  logic      read_serviced,
    output logic      read_req_valid,
    output tag_t      read_tag_0,
    output tag_t      read_tag_1,

    // kill bus
    input  logic      kill_valid,
    input  rob_idx_t  kill_rob_index,

    // restart from ex
    input  logic      flush,

    output bru_task_t rs_task,
    output logic      issue,
    output logic      rs_full
);

    //////////////////////////////////////////////////
    // entry state
    //////////////////////////////////////////////////

    logic rs_valid;

    // kill only lands on a task still in the rs
    logic kill_hit;

    // operand has a value now or next cycle
    logic op_0_ok;
    logic op_1_ok;

    // some operand comes from the register file
    logic raw_need;

    // all operands covered, read aside
    logic ops_ok;

    //////////////////////////////////////////////////
    // issue decision
    //////////////////////////////////////////////////

    assign kill_hit = rs_valid & kill_valid & (rs_task.rob_index == kill_rob_index);

    // unused operand never blocks
    assign op_0_ok = ~rs_task.source_0.needed | rs_task.source_0.ready | hit_0;
    assign op_1_ok = ~rs_task.source_1.needed | rs_task.source_1.ready | hit_1;
    assign ops_ok  = op_0_ok & op_1_ok;

    // ready means the value sits in the register file
    assign raw_need = (rs_task.source_0.needed & rs_task.source_0.ready) |
                      (rs_task.source_1.needed & rs_task.source_1.ready);

    // read only once the other operand is covered too
    assign read_req_valid = rs_valid & ~kill_hit & ops_ok & raw_need;
    assign read_tag_0     = rs_task.source_0.tag;
    assign read_tag_1     = rs_task.source_1.tag;

    // forwarded-only tasks skip the register file
    assign issue = rs_valid & ~kill_hit & ops_ok & (~raw_need | read_serviced);

    // task still waiting after this cycle
    assign rs_full = rs_valid & ~kill_hit & ~issue;

    //////////////////////////////////////////////////
    // valid bit
    //////////////////////////////////////////////////

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            rs_valid <= 1'b0;
        end else if (flush) begin
            // same cycle dispatch is dropped too
            rs_valid <= 1'b0;
        end else if (dispatch_valid) begin
            rs_valid <= 1'b1;
        end else if (issue | kill_hit) begin
            rs_valid <= 1'b0;
        end
    end

    //////////////////////////////////////////////////
    // task payload
    //////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (dispatch_valid) begin
            rs_task <= dispatch_task;
        end else begin
            // a tag seen while stalled is now in the register file
            if (hit_0) begin
                rs_task.source_0.ready <= 1'b1;
            end
            if (hit_1) begin
                rs_task.source_1.ready <= 1'b1;
            end
        end
    end

endmodule

// File: source/bru_ex_latch.sv
// rs to ex pipeline register with next pc and branch target adds
module bru_ex_latch
    import bru_pkg::*;
(
    input  logic      CLK,
    input  logic      nRST,

    // issued task and its operand routing
    input  logic      issue,
    input  bru_task_t rs_task,
    input  src_sel_t  sel_0,
    input  src_sel_t  sel_1,

    // register file read data, same cycle as issue
    input  word_t     read_data_0,
    input  word_t     read_data_1,

    input  logic      flush,
    output ex_task_t  ex
);

    // next state of the stage
    ex_task_t ex_next;

    // registered halves
    logic     ex_valid;
    ex_task_t ex_body;

    //////////////////////////////////////////////////
    // rs stage math
    //////////////////////////////////////////////////

    always_comb begin
        ex_next.valid     = issue & ~flush;
        ex_next.op        = rs_task.op;
        ex_next.raw_0     = read_data_0;
        ex_next.raw_1     = read_data_1;
        ex_next.sel_0     = sel_0;
        ex_next.sel_1     = sel_1;
        // btb index is the low pc bits
        ex_next.btb_idx   = btb_idx_t'(rs_task.pc);
        // fall through, one word on
        ex_next.next_pc   = rs_task.pc + pc_t'(1);
        // imm truncated to pc width
        ex_next.branch_pc = rs_task.pc + pc_t'(1) + pc_t'(rs_task.imm16);
        ex_next.npc       = rs_task.npc;
        ex_next.ckpt_col  = rs_task.ckpt_col;
        ex_next.rob_index = rs_task.rob_index;
    end

    //////////////////////////////////////////////////
    // registers
    //////////////////////////////////////////////////

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= ex_next.valid;
        end
    end

    // payload only moves on issue
    always_ff @(posedge CLK) begin
        if (issue) begin
            ex_body <= ex_next;
        end
    end

    // valid comes from the reset flop
    always_comb begin
        ex       = ex_body;
        ex.valid = ex_valid;
    end

endmodule

// File: source/bru_resolve.sv
// ex stage forwarding mux, branch compare, restart, flush and btb update
`include "bru_defs.svh"

module bru_resolve
    import bru_pkg::*;
(
    input  ex_task_t    ex,

    // bus data for operands forwarded at issue
    input  cb_t         cb_0,
    input  cb_t         cb_1,
    input  cb_t         cb_2,

    output logic        complete_valid,
    output logic        restart_valid,
    output restart_t    restart,
    output logic        btb_update_valid,
    output btb_update_t btb_update,
    output logic        flush
);

    // forwarded or raw operand
    function automatic word_t pick(input src_sel_t s, input word_t raw,
                                   input word_t d0, input word_t d1, input word_t d2);
        word_t v;
        case (s)
            SEL_CB0: v = d0;
            SEL_CB1: v = d1;
            SEL_CB2: v = d2;
            default: v = raw;
        endcase
        return v;
    endfunction

    word_t op_a;
    word_t op_b;
    logic  taken;
    pc_t   jr_target;
    pc_t   resolved_pc;
    logic  mispredict;

    //////////////////////////////////////////////////
    // operands
    //////////////////////////////////////////////////

    assign op_a = pick(ex.sel_0, ex.raw_0, cb_0.data, cb_1.data, cb_2.data);
    assign op_b = pick(ex.sel_1, ex.raw_1, cb_0.data, cb_1.data, cb_2.data);

    // byte address in the register, drop the low two bits
    assign jr_target = op_a[`BRU_PC_W+1:2];

    //////////////////////////////////////////////////
    // resolution
    //////////////////////////////////////////////////

    always_comb begin
        taken       = 1'b0;
        resolved_pc = ex.next_pc;
        case (ex.op)
            BRU_BEQ: begin
                taken       = (op_a == op_b);
                resolved_pc = taken ? ex.branch_pc : ex.next_pc;
            end
            BRU_BNE: begin
                taken       = (op_a != op_b);
                resolved_pc = taken ? ex.branch_pc : ex.next_pc;
            end
            BRU_JR: begin
                resolved_pc = jr_target;
            end
            default: begin
                resolved_pc = ex.next_pc;
            end
        endcase
    end

    // fetch went somewhere else
    assign mispredict = (ex.npc != resolved_pc);

    assign complete_valid = ex.valid;
    assign restart_valid  = ex.valid & mispredict;
    // a restart also clears rs and ex
    assign flush          = restart_valid;

    assign restart.rob_index = ex.rob_index;
    assign restart.pc        = resolved_pc;
    assign restart.safe_col  = ex.ckpt_col;

    // only conditional branches train the predictor
    assign btb_update_valid  = ex.valid & (ex.op != BRU_JR);
    assign btb_update.idx    = ex.btb_idx;
    assign btb_update.target = ex.branch_pc;
    assign btb_update.taken  = taken;

endmodule

// File: source/bru_pipeline.sv
// branch resolution unit top, rs control, two wakeups, ex latch and resolve
module bru_pipeline
    import bru_pkg::*;
(
    input  logic        CLK,
    input  logic        nRST,

    // dispatch
    input  logic        dispatch_valid,
    input  bru_task_t   dispatch_task,
    output logic        rs_full,

    // register file
    output logic        read_req_valid,
    output tag_t        read_tag_0,
    output tag_t        read_tag_1,
    input  logic        read_serviced,
    input  word_t       read_data_0,
    input  word_t       read_data_1,

    // kill bus
    input  logic        kill_valid,
    input  rob_idx_t    kill_rob_index,

    // complete buses
    input  cb_t         cb_0,
    input  cb_t         cb_1,
    input  cb_t         cb_2,

    // rob and fetch side
    output logic        complete_valid,
    output logic        restart_valid,
    output restart_t    restart,
    output logic        btb_update_valid,
    output btb_update_t btb_update
);

    bru_task_t rs_task;
    logic      issue;
    logic      flush;
    logic      hit_0;
    logic      hit_1;
    src_sel_t  sel_0;
    src_sel_t  sel_1;
    ex_task_t  ex;

    //////////////////////////////////////////////////
    // rs stage
    //////////////////////////////////////////////////

    bru_rs_control i_rs_control (
        .CLK            (CLK),
        .nRST           (nRST),
        .dispatch_valid (dispatch_valid),
        .dispatch_task  (dispatch_task),
        .hit_0          (hit_0),
        .hit_1          (hit_1),
        .read_serviced  (read_serviced),
        .read_req_valid (read_req_valid),
        .read_tag_0     (read_tag_0),
        .read_tag_1     (read_tag_1),
        .kill_valid     (kill_valid),
        .kill_rob_index (kill_rob_index),
        .flush          (flush),
        .rs_task        (rs_task),
        .issue          (issue),
        .rs_full        (rs_full)
    );

    // operand 0 wakeup
    bru_operand_wakeup i_wakeup_0 (
        .src  (rs_task.source_0),
        .cb_0 (cb_0),
        .cb_1 (cb_1),
        .cb_2 (cb_2),
        .hit  (hit_0),
        .sel  (sel_0)
    );

    // operand 1 wakeup
    bru_operand_wakeup i_wakeup_1 (
        .src  (rs_task.source_1),
        .cb_0 (cb_0),
        .cb_1 (cb_1),
        .cb_2 (cb_2),
        .hit  (hit_1),
        .sel  (sel_1)
    );

    //////////////////////////////////////////////////
    // ex stage
    //////////////////////////////////////////////////

    bru_ex_latch i_ex_latch (
        .CLK         (CLK),
        .nRST        (nRST),
        .issue       (issue),
        .rs_task     (rs_task),
        .sel_0       (sel_0),
        .sel_1       (sel_1),
        .read_data_0 (read_data_0),
        .read_data_1 (read_data_1),
        .flush       (flush),
        .ex          (ex)
    );

    bru_resolve i_resolve (
        .ex               (ex),
        .cb_0             (cb_0),
        .cb_1             (cb_1),
        .cb_2             (cb_2),
        .complete_valid   (complete_valid),
        .restart_valid    (restart_valid),
        .restart          (restart),
        .btb_update_valid (btb_update_valid),
        .btb_update       (btb_update),
        .flush            (flush)
    );

endmodule

// File: test/bru_pipeline_tb.sv
// bru pipeline testbench with stimulus, reference model, compare process, watchdog and report
`include "bru_defs.svh"

module bru_pipeline_tb
    import bru_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 200;
    localparam int DONE_LIMIT      = 50;

    // expected outputs of one completion
    typedef struct packed {
        logic        restart_valid;
        restart_t    restart;
        logic        btb_valid;
        btb_update_t btb;
    } exp_t;

    logic        CLK = 1'b0;
    logic        nRST;
    logic        dispatch_valid;
    bru_task_t   dispatch_task;
    logic        rs_full;
    logic        read_req_valid;
    tag_t        read_tag_0;
    tag_t        read_tag_1;
    logic        read_serviced;
    word_t       read_data_0;
    word_t       read_data_1;
    logic        kill_valid;
    rob_idx_t    kill_rob_index;
    cb_t         cb_0;
    cb_t         cb_1;
    cb_t         cb_2;
    logic        complete_valid;
    logic        restart_valid;
    restart_t    restart;
    logic        btb_update_valid;
    btb_update_t btb_update;

    logic [31:0] seed = 32'h9425_3824;
    exp_t        exp_q[$];
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          test_start_errors = 0;

    bru_pipeline i_dut (.*);

    // 10 ns clock
    always #5 CLK = ~CLK;

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic word_t next_rand();
        seed = xorshift(seed);
        return seed;
    endfunction

    // expected result from the branch rules with pc counted in words
    function automatic exp_t ref_result(input bru_task_t t, input word_t a, input word_t b);
        exp_t e;
        pc_t  next_pc;
        pc_t  target;
        pc_t  res;
        logic taken;
        next_pc = t.pc + pc_t'(1);
        target  = t.pc + pc_t'(1) + t.imm16[`BRU_PC_W-1:0];
        taken   = 1'b0;
        if (t.op == BRU_BEQ) begin
            taken = (a == b);
        end else if (t.op == BRU_BNE) begin
            taken = (a != b);
        end
        // jr target is a byte address in the register
        if (t.op == BRU_JR) begin
            res = a[`BRU_PC_W+1:2];
        end else begin
            res = taken ? target : next_pc;
        end
        e.restart_valid      = (t.npc != res);
        e.restart.rob_index  = t.rob_index;
        e.restart.pc         = res;
        e.restart.safe_col   = t.ckpt_col;
        e.btb_valid          = (t.op != BRU_JR);
        e.btb.idx            = t.pc[`BRU_BTB_IDX_W-1:0];
        e.btb.target         = target;
        e.btb.taken          = taken;
        return e;
    endfunction

    // random task with both operands ready in the register file
    function automatic bru_task_t new_task(input bru_op_t op);
        bru_task_t t;
        t.op              = op;
        t.source_0.needed = 1'b1;
        t.source_0.ready  = 1'b1;
        t.source_0.tag    = tag_t'(next_rand());
        t.source_1.needed = (op != BRU_JR);
        t.source_1.ready  = 1'b1;
        t.source_1.tag    = tag_t'(next_rand());
        t.imm16           = next_rand();
        t.pc              = pc_t'(next_rand());
        t.npc             = t.pc + pc_t'(1);
        t.ckpt_col        = ckpt_col_t'(next_rand());
        t.rob_index       = rob_idx_t'(next_rand());
        return t;
    endfunction

    // set npc to the right or a wrong prediction
    function automatic bru_task_t predict(input bru_task_t t, input word_t a, input word_t b,
                                          input logic good);
        exp_t e;
        e     = ref_result(t, a, b);
        t.npc = good ? e.restart.pc : e.restart.pc + pc_t'(1);
        return t;
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            $display("FAILED %s: got %h expected %h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    // inputs change 1 ns after the edge
    task automatic step();
        @(posedge CLK);
        #1;
    endtask

    task automatic set_bus(input int i, input logic v, input tag_t tag, input word_t d);
        cb_t c;
        c.tag_valid = v;
        c.tag       = tag;
        c.data      = d;
        case (i)
            0: cb_0 = c;
            1: cb_1 = c;
            default: cb_2 = c;
        endcase
    endtask

    task automatic clear_buses();
        cb_0 = '0;
        cb_1 = '0;
        cb_2 = '0;
    endtask

    task automatic dispatch(input bru_task_t t);
        dispatch_task  = t;
        dispatch_valid = 1'b1;
        step();
        dispatch_valid = 1'b0;
    endtask

    // until the compare process has consumed every expectation
    task automatic wait_done();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < DONE_LIMIT) begin
            step();
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("no completion within %0d cycles at %0t", DONE_LIMIT, $time);
            errors++;
            exp_q.delete();
        end
    endtask

    // both operands from the register file and the read serviced at once
    task automatic run_ready(input bru_task_t t, input word_t a, input word_t b);
        read_data_0 = a;
        read_data_1 = b;
        exp_q.push_back(ref_result(t, a, b));
        dispatch(t);
        wait_done();
        step();
    endtask

    task automatic report(input string name);
        tests++;
        if (errors == test_start_errors) begin
            $display("test %0d %s: pass", tests, name);
        end else begin
            $display("test %0d %s: %0d errors", tests, name, errors - test_start_errors);
        end
        test_start_errors = errors;
    endtask

    //////////////////////////////////////////////////
    // compare process
    //////////////////////////////////////////////////

    // outputs settle well before the falling edge
    always @(negedge CLK) begin : compare_outputs
        exp_t e;
        if (nRST && complete_valid) begin
            if (exp_q.size() == 0) begin
                $display("completion with no task expected at %0t", $time);
                errors++;
            end else begin
                e = exp_q.pop_front();
                check("restart_valid", restart_valid, e.restart_valid);
                if (e.restart_valid) begin
                    check("restart", restart, e.restart);
                end
                check("btb_update_valid", btb_update_valid, e.btb_valid);
                if (e.btb_valid) begin
                    check("btb_update", btb_update, e.btb);
                end
            end
        end
    end

    // watchdog
    initial begin
        repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge CLK);
        $display("run did not finish within %0d cycles", NUM_TESTS * CYCLES_PER_TEST);
        $display("Test FAILED");
        $finish;
    end

    //////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////

    task automatic test_ready_branches();
        bru_task_t t;
        word_t     a;
        word_t     b;
        logic [31:0] r;
        for (int i = 0; i < 8; i++) begin
            r = next_rand();
            a = next_rand();
            b = r[1] ? a : next_rand();
            t = new_task(r[0] ? BRU_BNE : BRU_BEQ);
            t = predict(t, a, b, r[2]);
            run_ready(t, a, b);
        end
        report("ready beq and bne");
    endtask

    task automatic test_forwarding();
        bru_task_t t;
        word_t     a;
        word_t     b;
        // both operands forwarded on different buses
        a = next_rand();
        b = a;
        t = new_task(BRU_BNE);
        t.source_0.ready = 1'b0;
        t.source_1.ready = 1'b0;
        t.source_1.tag   = t.source_0.tag ^ tag_t'(1);
        t = predict(t, a, b, 1'b0);
        read_data_0 = ~a;
        read_data_1 = ~b;
        exp_q.push_back(ref_result(t, a, b));
        dispatch(t);
        set_bus(2, 1'b1, t.source_0.tag, '0);
        set_bus(1, 1'b1, t.source_1.tag, '0);
        step();
        set_bus(2, 1'b0, '0, a);
        set_bus(1, 1'b0, '0, b);
        wait_done();
        clear_buses();
        step();
        // same tag on bus 0 and bus 2 where bus 0 data is the real one
        a = next_rand();
        b = a;
        t = new_task(BRU_BEQ);
        t.source_0.ready = 1'b0;
        t = predict(t, a, b, 1'b1);
        read_data_0 = ~a;
        read_data_1 = b;
        exp_q.push_back(ref_result(t, a, b));
        dispatch(t);
        set_bus(0, 1'b1, t.source_0.tag, '0);
        set_bus(2, 1'b1, t.source_0.tag, '0);
        step();
        set_bus(0, 1'b0, '0, a);
        set_bus(2, 1'b0, '0, ~a);
        wait_done();
        clear_buses();
        step();
        report("bus forwarding");
    endtask

    task automatic test_jr();
        bru_task_t t;
        word_t     a;
        a = next_rand();
        run_ready(predict(new_task(BRU_JR), a, '0, 1'b1), a, next_rand());
        a = next_rand();
        run_ready(predict(new_task(BRU_JR), a, '0, 1'b0), a, next_rand());
        // operand 0 forwarded on bus 1
        a = next_rand();
        t = new_task(BRU_JR);
        t.source_0.ready = 1'b0;
        t = predict(t, a, '0, 1'b0);
        read_data_0 = ~a;
        exp_q.push_back(ref_result(t, a, '0));
        dispatch(t);
        set_bus(1, 1'b1, t.source_0.tag, '0);
        step();
        set_bus(1, 1'b0, '0, a);
        wait_done();
        clear_buses();
        step();
        report("jr");
    endtask

    task automatic test_backpressure();
        bru_task_t t;
        word_t     a;
        word_t     b;
        a = next_rand();
        b = next_rand();
        t = predict(new_task(BRU_BEQ), a, b, 1'b1);
        // operand 0 wakes up while the read is stalled
        t.source_0.ready = 1'b0;
        read_serviced = 1'b0;
        dispatch(t);
        set_bus(1, 1'b1, t.source_0.tag, '0);
        for (int i = 0; i < 5; i++) begin
            @(negedge CLK);
            check("rs_full", rs_full, 1'b1);
            check("read_req_valid", read_req_valid, 1'b1);
            check("read_tag_0", read_tag_0, t.source_0.tag);
            check("read_tag_1", read_tag_1, t.source_1.tag);
            step();
            set_bus(1, 1'b0, '0, a);
        end
        clear_buses();
        read_data_0 = a;
        read_data_1 = b;
        read_serviced = 1'b1;
        exp_q.push_back(ref_result(t, a, b));
        wait_done();
        step();
        report("read back-pressure");
    endtask

    task automatic test_kill();
        bru_task_t t;
        t = new_task(BRU_BNE);
        t.source_0.ready = 1'b0;
        dispatch(t);
        repeat (2) begin
            @(negedge CLK);
            check("rs_full", rs_full, 1'b1);
            step();
        end
        kill_valid     = 1'b1;
        kill_rob_index = t.rob_index;
        @(negedge CLK);
        check("rs_full", rs_full, 1'b0);
        step();
        kill_valid = 1'b0;
        // a late tag must not revive the killed task
        set_bus(0, 1'b1, t.source_0.tag, '0);
        for (int i = 0; i < 4; i++) begin
            @(negedge CLK);
            check("rs_full", rs_full, 1'b0);
            step();
            clear_buses();
        end
        report("kill");
    endtask

    task automatic test_flush();
        bru_task_t ta;
        bru_task_t tb;
        word_t     a;
        word_t     b;
        a  = next_rand();
        b  = next_rand();
        ta = predict(new_task(BRU_BNE), a, b, 1'b0);
        tb = new_task(BRU_BEQ);
        // it waits on a tag that never comes, only the restart empties the rs
        tb.source_0.ready = 1'b0;
        read_data_0 = a;
        read_data_1 = b;
        exp_q.push_back(ref_result(ta, a, b));
        dispatch(ta);
        // second task enters the rs as the first one issues
        dispatch(tb);
        wait_done();
        for (int i = 0; i < 4; i++) begin
            @(negedge CLK);
            check("rs_full", rs_full, 1'b0);
            step();
        end
        a = next_rand();
        b = next_rand();
        run_ready(predict(new_task(BRU_BEQ), a, b, 1'b1), a, b);
        report("restart flush");
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        nRST           = 1'b0;
        dispatch_valid = 1'b0;
        dispatch_task  = '0;
        read_serviced  = 1'b1;
        read_data_0    = '0;
        read_data_1    = '0;
        kill_valid     = 1'b0;
        kill_rob_index = '0;
        clear_buses();
        repeat (2) @(posedge CLK);
        #1;
        nRST = 1'b1;
        step();
        test_ready_branches();
        test_forwarding();
        test_jr();
        test_backpressure();
        test_kill();
        test_flush();
        repeat (2) step();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+source
source/bru_pkg.sv
source/bru_operand_wakeup.sv
source/bru_rs_control.sv
source/bru_ex_latch.sv
source/bru_resolve.sv
source/bru_pipeline.sv
test/bru_pipeline_tb.sv
